//--- list.f
+incdir+tb
hdl/fdc_pkg.sv
hdl/mcu_bus_regs.sv
hdl/index_meter.sv
hdl/step_controller.sv
hdl/sram_port.sv
hdl/readback_mux.sv
hdl/fdc_top.sv
tb/tb_clock.sv
tb/fdc_tb.sv

//--- tb/fdc_tb_tasks.svh
`ifndef FDC_TB_TASKS_SVH
`define FDC_TB_TASKS_SVH

////////////////////////////////////////
// Random numbers

// Galois form with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	logic [31:0] n;
	n = s >> 1;
	if (s[0]) n = n ^ 32'h8020_0003;
	return n;
endfunction

// One step per bit taken
function automatic logic [31:0] random_bits(input int nbits);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < nbits; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		r = {r[30:0], lfsr_state[0]};
	end
	return r;
endfunction

function automatic byte_t random_byte();
	logic [31:0] r;
	r = random_bits(8);
	return r[7:0];
endfunction

////////////////////////////////////////
// Checking

task automatic fail_stop();
	$display("Something failed");
	$fatal(1, "stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("[FAIL] time %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
		fail_stop();
	end
endtask

task automatic report_timeout(input string what);
	$display("Timed out while waiting for %s", what);
	fail_stop();
endtask

////////////////////////////////////////
// Bus access

// Inputs change 5 units after the edge
task automatic tick();
	@(posedge CLK_MASTER);
	#5;
endtask

task automatic wait_cycles(input int n);
	repeat (n) tick();
endtask

task automatic latch_addr(input reg_addr_t addr);
	mcu_pmd   = addr;
	mcu_pmall = 1'b1;
	tick();
	mcu_pmall = 1'b0;
endtask

task automatic bus_write(input reg_addr_t addr, input byte_t data);
	latch_addr(addr);
	mcu_pmd  = data;
	mcu_pmwr = 1'b1;
	wait_cycles(3);   // Sync plus decode
	mcu_pmwr = 1'b0;
	wait_cycles(4);   // Strobes settle
endtask

task automatic bus_read(input reg_addr_t addr, output byte_t data);
	latch_addr(addr);
	mcu_pmrd = 1'b1;
	wait_cycles(4);   // Index byte latch done by now
	check_value("mcu_pmd_oe", mcu_pmd_oe, 1'b1);
	data     = mcu_rd_data;
	mcu_pmrd = 1'b0;
	wait_cycles(6);   // Read end, address step, new data captured
	check_value("mcu_pmd_oe", mcu_pmd_oe, 1'b0);
endtask

task automatic read_expect(input reg_addr_t addr, input byte_t exp, input string name);
	byte_t got;
	bus_read(addr, got);
	check_value(name, got, exp);
endtask

// Poll STATUS2 until the stepper is idle
task automatic wait_step_done();
	byte_t st;
	int    polls;
	polls = 0;
	st    = 8'h04;
	while (st[2]) begin
		bus_read(REG_STATUS2, st);
		polls++;
		if (polls > 200000) report_timeout("the seek to finish");
	end
endtask

`endif

//--- tb/fdc_tb.sv
module fdc_tb;
	import fdc_pkg::*;

	logic       CLK_MASTER;
	logic       rst;
	byte_t      mcu_pmd, mcu_rd_data;
	logic       mcu_pmalh, mcu_pmall, mcu_pmrd, mcu_pmwr, mcu_pmd_oe;
	sram_addr_t sram_a;
	byte_t      sram_dq_in, sram_dq_out;
	logic       sram_we_n, sram_oe_n;
	logic       fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_dchg_in, fd_dens_in;
	logic       fd_dens_out, fd_inuse, fd_moten, fd_sidesel, fd_step, fd_dir;
	logic [3:0] fd_drvsel;

	logic [31:0] lfsr_state = 32'h70be_1eed;
	byte_t       sram_mem [0:(1<<19)-1];   // 512k x 8 part
	int          step_pulses = 0;          // Falling edges of fd_step
	logic        step_prev = 1'b1;

	`include "fdc_tb_tasks.svh"

	tb_clock clock_i (.CLK_MASTER);

	fdc_top fdc_top_i (.CLK_MASTER, .rst, .mcu_pmd, .mcu_pmalh, .mcu_pmall, .mcu_pmrd,
		.mcu_pmwr, .mcu_rd_data, .mcu_pmd_oe, .sram_a, .sram_dq_in, .sram_dq_out,
		.sram_we_n, .sram_oe_n, .fd_index_in, .fd_track0_in, .fd_wrprot_in,
		.fd_rdy_dchg_in, .fd_dens_in, .fd_dens_out, .fd_inuse, .fd_drvsel, .fd_moten,
		.fd_sidesel, .fd_step, .fd_dir);

	////////////////////////////////////////
	// SRAM and drive models

	assign sram_dq_in = sram_oe_n ? 8'hFF : sram_mem[sram_a];  // Async read

	always @(posedge sram_we_n) begin
		if (!rst) sram_mem[sram_a] = sram_dq_out;  // Store on WE rise
	end

	// Step pulse counter
	always @(posedge CLK_MASTER) begin
		if (rst) begin
			step_prev <= 1'b1;
		end else begin
			if (step_prev && !fd_step) step_pulses <= step_pulses + 1;
			step_prev <= fd_step;
		end
	end

	////////////////////////////////////////
	// Stimulus

	initial begin
		byte_t       rd, val, cmd;
		byte_t       data_q [8];
		logic [3:0]  sel_exp;
		logic [31:0] r32;
		sram_addr_t  start, addr;
		int          ticks, count, base, timer;
		logic [15:0] period;

		rst            = 1'b1;
		mcu_pmd        = 8'h00;
		mcu_pmalh      = 1'b0;
		mcu_pmall      = 1'b0;
		mcu_pmrd       = 1'b0;
		mcu_pmwr       = 1'b0;
		fd_index_in    = 1'b0;
		fd_track0_in   = 1'b0;
		fd_wrprot_in   = random_bits(1) != 0;
		fd_rdy_dchg_in = random_bits(1) != 0;
		fd_dens_in     = random_bits(1) != 0;
		for (int i = 0; i < (1 << 19); i++) begin
			sram_mem[i] = i[7:0] ^ i[15:8] ^ {5'b00000, i[18:16]};  // Whole address
		end
		wait_cycles(10);
		rst = 1'b0;
		wait_cycles(2);
		mcu_pmalh = 1'b1;   // Page 0
		tick();
		mcu_pmalh = 1'b0;

		// Scratchpad, identity, fixed bytes, idle status
		repeat (20) begin
			val = random_byte();
			bus_write(REG_SCRATCH, val);
			read_expect(REG_SCRATCH, val, "scratchpad");
			read_expect(REG_SCRATCH_INV, ~val, "scratchpad inverse");
		end
		read_expect(REG_FIXED_55, 8'h55, "fixed 55");
		read_expect(REG_FIXED_AA, 8'hAA, "fixed AA");
		read_expect(REG_MCO_TYPE_L, MCO_TYPE[7:0], "MCO type low");
		read_expect(REG_MCO_TYPE_H, MCO_TYPE[15:8], "MCO type high");
		read_expect(REG_MCO_VER_L, MCO_VERSION[7:0], "MCO version low");
		read_expect(REG_MCO_VER_H, MCO_VERSION[15:8], "MCO version high");
		read_expect(REG_STATUS2, {2'b00, fd_wrprot_in, fd_rdy_dchg_in, fd_dens_in, 3'b000},
			"STATUS2");

		// Drive outputs are inverted control bits
		repeat (10) begin
			val = random_byte();
			bus_write(REG_DRIVE_CONTROL, val);
			sel_exp = ~val[5:2];
			check_value("fd_dens_out", fd_dens_out, !val[0]);
			check_value("fd_inuse", fd_inuse, !val[1]);
			check_value("fd_drvsel", fd_drvsel, sel_exp);
			check_value("fd_moten", fd_moten, !val[6]);
			check_value("fd_sidesel", fd_sidesel, !val[7]);
		end

		// SRAM burst write then read back
		r32   = random_bits(19);
		start = r32[18:0];
		bus_write(REG_SRAM_ADDR_UPPER, {5'b00000, start[18:16]});
		bus_write(REG_SRAM_ADDR_HIGH, start[15:8]);
		bus_write(REG_SRAM_ADDR_LOW, start[7:0]);
		for (int i = 0; i < 8; i++) begin
			data_q[i] = random_byte();
			bus_write(REG_SRAM_DATA, data_q[i]);
			wait_cycles(12);   // Write sequence idle again
		end
		addr = start + 19'd8;   // Wraps at 512k
		read_expect(REG_SRAM_ADDR_LOW, addr[7:0], "sram_a low");
		read_expect(REG_SRAM_ADDR_HIGH, addr[15:8], "sram_a high");
		read_expect(REG_SRAM_ADDR_UPPER, {5'b00000, addr[18:16]}, "sram_a upper");
		for (int i = 0; i < 8; i++) begin
			addr = start + 19'(i);
			check_value("sram_mem", sram_mem[addr], data_q[i]);
		end
		bus_write(REG_SRAM_ADDR_UPPER, {5'b00000, start[18:16]});
		bus_write(REG_SRAM_ADDR_HIGH, start[15:8]);
		bus_write(REG_SRAM_ADDR_LOW, start[7:0]);
		for (int i = 0; i < 8; i++) begin
			read_expect(REG_SRAM_DATA, data_q[i], "SRAM data");
		end

		// Random seek with track 0 clear
		val = random_byte();
		bus_write(REG_STEP_RATE, {6'b000000, val[1:0]});
		r32   = random_bits(8);
		count = 1 + int'(r32 % 6);
		r32   = random_bits(1);
		cmd   = count[7:0];
		cmd[7] = r32[0];   // Direction
		base  = step_pulses;
		bus_write(REG_STEP_CMD, cmd);
		bus_read(REG_STATUS2, rd);
		check_value("STATUS2[2] busy", rd[2], 1'b1);
		wait_step_done();
		check_value("fd_step pulses", step_pulses - base, count);
		check_value("fd_dir", fd_dir, cmd[7]);

		// Outward seek cut short by track 0
		bus_write(REG_STEP_RATE, 8'h00);
		base = step_pulses;
		bus_write(REG_STEP_CMD, 8'h06);
		timer = 0;
		while (!((step_pulses - base >= 2) && fd_step)) begin
			tick();
			timer++;
			if (timer > 400000) report_timeout("the second step pulse");
		end
		fd_track0_in = 1'b1;
		wait_step_done();
		check_value("fd_step pulses", step_pulses - base, 2);
		check_value("fd_dir", fd_dir, 1'b0);
		bus_read(REG_STATUS1, rd);
		check_value("STATUS1[4]", rd[4], 1'b1);
		fd_track0_in = 1'b0;

		// Index period from three evenly spaced pulses
		r32   = random_bits(8);
		ticks = 20 + int'(r32 % 41);
		repeat (3) begin
			fd_index_in = 1'b1;
			wait_cycles(10);
			fd_index_in = 1'b0;
			wait_cycles(ticks * INDEX_TICK_DIV - 10);
		end
		bus_read(REG_STATUS1, rd);
		check_value("STATUS1[3] before read", rd[3], 1'b1);
		bus_read(REG_INDEX_HIGH, rd);
		period[15:8] = rd;
		bus_read(REG_INDEX_LOW, rd);
		period[7:0] = rd;
		if (period + 1 < ticks || period > ticks + 1)
			check_value("index period", period, ticks);   // Off by more than one tick
		bus_read(REG_STATUS1, rd);
		check_value("STATUS1[3] after read", rd[3], 1'b0);

		$display("Everything OK");
		$finish;
	end

endmodule

//--- tb/tb_clock.sv
module tb_clock (
	output logic CLK_MASTER
);

	// Free running, 40 unit period
	initial CLK_MASTER = 1'b0;

	always begin
		#20;
		CLK_MASTER = ~CLK_MASTER;
	end

endmodule

//--- hdl/fdc_top.sv
module fdc_top (
	input  logic                CLK_MASTER,
	input  logic                rst,
	// MCU bus
	input  fdc_pkg::byte_t      mcu_pmd,
	input  logic                mcu_pmalh,
	input  logic                mcu_pmall,
	input  logic                mcu_pmrd,
	input  logic                mcu_pmwr,
	output fdc_pkg::byte_t      mcu_rd_data,
	output logic                mcu_pmd_oe,
	// SRAM
	output fdc_pkg::sram_addr_t sram_a,
	input  fdc_pkg::byte_t      sram_dq_in,
	output fdc_pkg::byte_t      sram_dq_out,
	output logic                sram_we_n,
	output logic                sram_oe_n,
	// Drive
	input  logic                fd_index_in,
	input  logic                fd_track0_in,
	input  logic                fd_wrprot_in,
	input  logic                fd_rdy_dchg_in,
	input  logic                fd_dens_in,
	output logic                fd_dens_out,
	output logic                fd_inuse,
	output logic [3:0]          fd_drvsel,
	output logic                fd_moten,
	output logic                fd_sidesel,
	output logic                fd_step,
	output logic                fd_dir
);
	import fdc_pkg::*;

	reg_addr_t  reg_addr;
	byte_t      wr_data, drive_control, step_rate, scratchpad;
	byte_t      sram_rd_data, index_high, index_low;
	logic [2:0] sram_addr_wr;
	logic       step_cmd_wr, sram_data_wr, sram_rd_end, index_high_rd;
	logic       new_index, stepping, track0_hit;

	assign mcu_pmd_oe = mcu_pmrd;  // Drive PMD while host reads

	mcu_bus_regs mcu_bus_regs_i (.CLK_MASTER, .rst, .mcu_pmd, .mcu_pmalh, .mcu_pmall,
		.mcu_pmrd, .mcu_pmwr, .reg_addr, .wr_data, .step_cmd_wr, .sram_data_wr,
		.sram_addr_wr, .sram_rd_end, .index_high_rd, .drive_control, .step_rate, .scratchpad);

	index_meter index_meter_i (.CLK_MASTER, .rst, .fd_index_in, .index_high_rd,
		.index_high, .index_low, .new_index);

	step_controller step_controller_i (.CLK_MASTER, .rst, .step_rate, .step_cmd_wr,
		.wr_data, .fd_track0_in, .fd_step, .fd_dir, .stepping, .track0_hit);

	sram_port sram_port_i (.CLK_MASTER, .rst, .sram_addr_wr, .sram_data_wr, .sram_rd_end,
		.wr_data, .sram_dq_in, .sram_a, .sram_dq_out, .sram_we_n, .sram_oe_n, .sram_rd_data);

	readback_mux readback_mux_i (.reg_addr, .scratchpad, .drive_control, .sram_a,
		.sram_rd_data, .index_high, .index_low, .new_index, .stepping, .track0_hit,
		.fd_index_in, .fd_track0_in, .fd_wrprot_in, .fd_rdy_dchg_in, .fd_dens_in,
		.mcu_rd_data, .fd_dens_out, .fd_inuse, .fd_drvsel, .fd_moten, .fd_sidesel);

endmodule

//--- hdl/readback_mux.sv
module readback_mux (
	input  fdc_pkg::reg_addr_t  reg_addr,
	input  fdc_pkg::byte_t      scratchpad,
	input  fdc_pkg::byte_t      drive_control,
	input  fdc_pkg::sram_addr_t sram_a,
	input  fdc_pkg::byte_t      sram_rd_data,
	input  fdc_pkg::byte_t      index_high,
	input  fdc_pkg::byte_t      index_low,
	input  logic                new_index,
	input  logic                stepping,
	input  logic                track0_hit,
	input  logic                fd_index_in,
	input  logic                fd_track0_in,
	input  logic                fd_wrprot_in,
	input  logic                fd_rdy_dchg_in,
	input  logic                fd_dens_in,
	output fdc_pkg::byte_t      mcu_rd_data,
	output logic                fd_dens_out,
	output logic                fd_inuse,
	output logic [3:0]          fd_drvsel,
	output logic                fd_moten,
	output logic                fd_sidesel
);
	import fdc_pkg::*;

	////////////////////////////////////////
	// Register readback

	always_comb begin
		case (reg_addr)
			REG_SRAM_ADDR_LOW:   mcu_rd_data = sram_a[7:0];
			REG_SRAM_ADDR_HIGH:  mcu_rd_data = sram_a[15:8];
			REG_SRAM_ADDR_UPPER: mcu_rd_data = {5'b00000, sram_a[18:16]};
			REG_SRAM_DATA:       mcu_rd_data = sram_rd_data;
			REG_MCO_TYPE_L:      mcu_rd_data = MCO_TYPE[7:0];
			REG_MCO_TYPE_H:      mcu_rd_data = MCO_TYPE[15:8];
			REG_MCO_VER_L:       mcu_rd_data = MCO_VERSION[7:0];
			REG_MCO_VER_H:       mcu_rd_data = MCO_VERSION[15:8];
			REG_STATUS1:         mcu_rd_data = {3'b000, track0_hit, new_index, 3'b000};
			REG_STATUS2:         mcu_rd_data = {fd_index_in, fd_track0_in, fd_wrprot_in,
				fd_rdy_dchg_in, fd_dens_in, stepping, 2'b00};  // No SRAM flags
			REG_SCRATCH:         mcu_rd_data = scratchpad;
			REG_SCRATCH_INV:     mcu_rd_data = ~scratchpad;
			REG_FIXED_55:        mcu_rd_data = 8'h55;
			REG_FIXED_AA:        mcu_rd_data = 8'hAA;
			REG_INDEX_HIGH:      mcu_rd_data = index_high;
			REG_INDEX_LOW:       mcu_rd_data = index_low;   // Held copy
			default:             mcu_rd_data = 8'h00;
		endcase
	end

	// Drive outputs, all active low
	assign fd_dens_out = ~drive_control[0];
	assign fd_inuse    = ~drive_control[1];
	assign fd_drvsel   = ~drive_control[5:2];
	assign fd_moten    = ~drive_control[6];
	assign fd_sidesel  = ~drive_control[7];

endmodule

//--- hdl/sram_port.sv
module sram_port (
	input  logic                CLK_MASTER,
	input  logic                rst,
	input  logic [2:0]          sram_addr_wr,  // Upper, high, low
	input  logic                sram_data_wr,
	input  logic                sram_rd_end,
	input  fdc_pkg::byte_t      wr_data,
	input  fdc_pkg::byte_t      sram_dq_in,
	output fdc_pkg::sram_addr_t sram_a,
	output fdc_pkg::byte_t      sram_dq_out,
	output logic                sram_we_n,
	output logic                sram_oe_n,
	output fdc_pkg::byte_t      sram_rd_data
);
	import fdc_pkg::*;

	sram_wr_state_e wr_state;
	logic           wr_busy;
	logic           addr_inc;

	////////////////////////////////////////
	// Write sequencer

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			wr_state  <= WR_IDLE;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;
		end else begin
			case (wr_state)
				WR_IDLE: if (sram_data_wr) begin
					sram_oe_n <= 1'b1;  // SRAM off the bus first
					wr_state  <= WR_OE_OFF;
				end
				WR_OE_OFF: begin
					sram_we_n <= 1'b0;
					wr_state  <= WR_WRITE;
				end
				WR_WRITE: begin
					sram_we_n <= 1'b1;  // Byte stored on this edge
					wr_state  <= WR_WRITE_END;
				end
				WR_WRITE_END: wr_state <= WR_INC_ADDR;
				WR_INC_ADDR: begin
					sram_oe_n <= 1'b0;  // Back to read mode
					wr_state  <= WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	assign wr_busy  = (wr_state != WR_IDLE);
	assign addr_inc = (wr_state == WR_INC_ADDR) || sram_rd_end;

	// Single byte write buffer
	always_ff @(posedge CLK_MASTER) begin
		if (sram_data_wr && !wr_busy) sram_dq_out <= wr_data;
	end

	////////////////////////////////////////
	// Address counter

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			sram_a <= '0;
		end else if (addr_inc) begin
			sram_a <= sram_a + 1'b1;
		end else if (!wr_busy) begin  // Loads ignored mid-write
			if (sram_addr_wr[0]) sram_a[7:0]   <= wr_data;
			if (sram_addr_wr[1]) sram_a[15:8]  <= wr_data;
			if (sram_addr_wr[2]) sram_a[18:16] <= wr_data[2:0];
		end
	end

	// Track current location while reading
	always_ff @(posedge CLK_MASTER) begin
		if (!sram_oe_n) sram_rd_data <= sram_dq_in;
	end

endmodule

//--- hdl/step_controller.sv
module step_controller (
	input  logic           CLK_MASTER,
	input  logic           rst,
	input  fdc_pkg::byte_t step_rate,
	input  logic           step_cmd_wr,
	input  fdc_pkg::byte_t wr_data,
	input  logic           fd_track0_in,
	output logic           fd_step,      // Active low
	output logic           fd_dir,       // 0 = outward
	output logic           stepping,
	output logic           track0_hit
);
	import fdc_pkg::*;

	localparam int TICK_W = $clog2(STEP_TICK_DIV);

	logic [TICK_W-1:0] tick_cnt;
	logic              tick_250us;
	byte_t             rate_cnt;
	logic              step_clk, step_clk_prev;
	logic              step_clk_rise, step_clk_fall;
	logic [1:0]        track0_sync;
	step_count_t       steps_left;
	step_state_e       step_state;

	////////////////////////////////////////
	// Step clock generation

	always_ff @(posedge CLK_MASTER) begin
		if (rst || tick_250us) tick_cnt <= '0;
		else                   tick_cnt <= tick_cnt + 1'b1;
	end

	assign tick_250us = (tick_cnt == TICK_W'(STEP_TICK_DIV - 1));

	// Toggle every step_rate+1 ticks
	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			rate_cnt      <= '0;
			step_clk      <= 1'b0;
			step_clk_prev <= 1'b0;
		end else begin
			step_clk_prev <= step_clk;
			if (tick_250us) begin
				if (rate_cnt >= step_rate) begin  // Also catches a lowered rate
					rate_cnt <= '0;
					step_clk <= ~step_clk;
				end else begin
					rate_cnt <= rate_cnt + 1'b1;
				end
			end
		end
	end

	assign step_clk_rise = step_clk & ~step_clk_prev;
	assign step_clk_fall = ~step_clk & step_clk_prev;

	always_ff @(posedge CLK_MASTER) begin
		if (rst) track0_sync <= '0;
		else     track0_sync <= {track0_sync[0], fd_track0_in};
	end

	////////////////////////////////////////
	// Stepping FSM

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			step_state <= STEP_IDLE;
			fd_step    <= 1'b1;
			fd_dir     <= 1'b0;
			steps_left <= '0;
			track0_hit <= 1'b0;
		end else begin
			case (step_state)
				STEP_IDLE: if (step_cmd_wr) begin
					fd_dir     <= wr_data[7];     // Direction in MSB
					steps_left <= wr_data[6:0];
					track0_hit <= 1'b0;
					step_state <= (wr_data[6:0] == 7'd0) ? STEP_DONE : STEP_PULSE_HIGH;
				end
				STEP_PULSE_HIGH: if (step_clk_rise) begin
					if (!fd_dir && track0_sync[1]) begin  // Head already home
						track0_hit <= 1'b1;
						step_state <= STEP_DONE;
					end else begin
						fd_step    <= 1'b0;
						step_state <= STEP_PULSE_LOW;
					end
				end
				STEP_PULSE_LOW: if (step_clk_fall) begin  // Half a step period low
					fd_step    <= 1'b1;
					steps_left <= steps_left - 1'b1;
					step_state <= (steps_left == 7'd1) ? STEP_DONE : STEP_PULSE_HIGH;
				end
				STEP_DONE: step_state <= STEP_IDLE;
				default:   step_state <= STEP_IDLE;
			endcase
		end
	end

	assign stepping = (step_state != STEP_IDLE);

endmodule

//--- hdl/index_meter.sv
module index_meter (
	input  logic           CLK_MASTER,
	input  logic           rst,
	input  logic           fd_index_in,
	input  logic           index_high_rd,
	output fdc_pkg::byte_t index_high,
	output fdc_pkg::byte_t index_low,
	output logic           new_index
);
	import fdc_pkg::*;

	localparam int TICK_W = $clog2(INDEX_TICK_DIV);

	logic [2:0]        index_sync;  // meta, sync, previous
	logic              index_rise;
	logic [TICK_W-1:0] tick_cnt;
	logic              tick_10us;
	index_count_t      period_cnt;  // Running count
	index_count_t      period_lat;  // Last full period

	always_ff @(posedge CLK_MASTER) begin
		if (rst) index_sync <= '0;
		else     index_sync <= {index_sync[1:0], fd_index_in};
	end

	assign index_rise = index_sync[1] & ~index_sync[2];

	// 10us tick
	always_ff @(posedge CLK_MASTER) begin
		if (rst || tick_10us) tick_cnt <= '0;
		else                  tick_cnt <= tick_cnt + 1'b1;
	end

	assign tick_10us = (tick_cnt == TICK_W'(INDEX_TICK_DIV - 1));

	////////////////////////////////////////
	// Period measurement

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			period_cnt <= '0;
			period_lat <= '0;
			index_low  <= '0;
			new_index  <= 1'b0;
		end else begin
			if (index_rise) begin
				period_lat <= period_cnt;  // Save and restart
				period_cnt <= '0;
			end else if (tick_10us) begin
				period_cnt <= period_cnt + 1'b1;
			end
			// Hold low byte so both halves come from one reading
			if (index_high_rd) index_low <= period_lat[7:0];
			// Read wins over a new edge in the same cycle
			if (index_high_rd)   new_index <= 1'b0;
			else if (index_rise) new_index <= 1'b1;
		end
	end

	assign index_high = period_lat[15:8];

endmodule

//--- hdl/mcu_bus_regs.sv
module mcu_bus_regs (
	input  logic              CLK_MASTER,
	input  logic              rst,
	input  fdc_pkg::byte_t    mcu_pmd,
	input  logic              mcu_pmalh,
	input  logic              mcu_pmall,
	input  logic              mcu_pmrd,
	input  logic              mcu_pmwr,
	output fdc_pkg::reg_addr_t reg_addr,
	output fdc_pkg::byte_t    wr_data,
	output logic              step_cmd_wr,
	output logic              sram_data_wr,
	output logic [2:0]        sram_addr_wr,  // Upper, high, low
	output logic              sram_rd_end,
	output logic              index_high_rd,
	output fdc_pkg::byte_t    drive_control,
	output fdc_pkg::byte_t    step_rate,
	output fdc_pkg::byte_t    scratchpad
);
	import fdc_pkg::*;

	byte_t addr_high;                          // Page select, only page 0 decodes
	logic  page0;
	logic  [2:0] pmwr_sync, pmrd_sync;        // meta, sync, previous
	logic  wr_pulse, rd_pulse, rd_end_pulse;

	////////////////////////////////////////
	// Address latch

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			addr_high <= '0;
			reg_addr  <= '0;
		end else begin
			if (mcu_pmalh) addr_high <= mcu_pmd;
			if (mcu_pmall) reg_addr <= mcu_pmd;
		end
	end

	assign page0 = (addr_high == 8'h00);

	// Strobe synchronisers
	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			pmwr_sync <= '0;
			pmrd_sync <= '0;
		end else begin
			pmwr_sync <= {pmwr_sync[1:0], mcu_pmwr};
			pmrd_sync <= {pmrd_sync[1:0], mcu_pmrd};
		end
	end

	assign wr_pulse     = pmwr_sync[1] & ~pmwr_sync[2];  // PMWR rise
	assign rd_pulse     = pmrd_sync[1] & ~pmrd_sync[2];  // PMRD rise
	assign rd_end_pulse = ~pmrd_sync[1] & pmrd_sync[2];  // PMRD fall

	////////////////////////////////////////
	// Write decode and registers

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			step_cmd_wr   <= 1'b0;
			sram_data_wr  <= 1'b0;
			sram_addr_wr  <= '0;
			sram_rd_end   <= 1'b0;
			index_high_rd <= 1'b0;
			drive_control <= '0;
			step_rate     <= '0;
			scratchpad    <= '0;
		end else begin
			// Command strobes last one cycle
			step_cmd_wr  <= 1'b0;
			sram_data_wr <= 1'b0;
			sram_addr_wr <= '0;
			if (wr_pulse && page0) begin
				case (reg_addr)
					REG_SRAM_ADDR_LOW:   sram_addr_wr[0] <= 1'b1;
					REG_SRAM_ADDR_HIGH:  sram_addr_wr[1] <= 1'b1;
					REG_SRAM_ADDR_UPPER: sram_addr_wr[2] <= 1'b1;
					REG_SRAM_DATA:       sram_data_wr <= 1'b1;
					REG_DRIVE_CONTROL:   drive_control <= mcu_pmd;
					REG_SCRATCH:         scratchpad <= mcu_pmd;
					REG_STEP_RATE:       step_rate <= mcu_pmd;
					REG_STEP_CMD:        step_cmd_wr <= 1'b1;
					default:             ;  // Read-only or unused
				endcase
			end
			// Reads with side effects
			index_high_rd <= rd_pulse && page0 && (reg_addr == REG_INDEX_HIGH);
			sram_rd_end   <= rd_end_pulse && page0 && (reg_addr == REG_SRAM_DATA);
		end
	end

	// Data byte held alongside its strobe
	always_ff @(posedge CLK_MASTER) begin
		if (wr_pulse) wr_data <= mcu_pmd;
	end

endmodule

//--- hdl/fdc_pkg.sv
package fdc_pkg;

	////////////////////////////////////////
	// Data types

	typedef logic [7:0]  byte_t;         // One register byte
	typedef logic [7:0]  reg_addr_t;     // Low byte of bus address
	typedef logic [18:0] sram_addr_t;    // 512k SRAM address
	typedef logic [15:0] index_count_t;  // Index period, 10us units
	typedef logic [6:0]  step_count_t;   // Steps still to issue

	// Stepper FSM, PULSE_HIGH waits for the step clock with the line idle
	typedef enum logic [1:0] {
		STEP_IDLE,
		STEP_PULSE_LOW,
		STEP_PULSE_HIGH,
		STEP_DONE
	} step_state_e;

	// SRAM byte write sequence
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_OE_OFF,       // Release the data bus
		WR_WRITE,        // WE low
		WR_WRITE_END,    // WE back high, data still driven
		WR_INC_ADDR      // Step the address on
	} sram_wr_state_e;

	////////////////////////////////////////
	// Register map

	localparam reg_addr_t REG_SRAM_ADDR_LOW   = 8'h00;
	localparam reg_addr_t REG_SRAM_ADDR_HIGH  = 8'h01;
	localparam reg_addr_t REG_SRAM_ADDR_UPPER = 8'h02;
	localparam reg_addr_t REG_SRAM_DATA       = 8'h03;
	localparam reg_addr_t REG_DRIVE_CONTROL   = 8'h04;  // Write side of 04
	localparam reg_addr_t REG_MCO_TYPE_L      = 8'h04;  // Read side of 04
	localparam reg_addr_t REG_MCO_TYPE_H      = 8'h05;
	localparam reg_addr_t REG_MCO_VER_L       = 8'h06;
	localparam reg_addr_t REG_MCO_VER_H       = 8'h07;
	localparam reg_addr_t REG_STATUS1         = 8'h0E;
	localparam reg_addr_t REG_STATUS2         = 8'h0F;
	localparam reg_addr_t REG_SCRATCH         = 8'h30;
	localparam reg_addr_t REG_SCRATCH_INV     = 8'h31;
	localparam reg_addr_t REG_FIXED_55        = 8'h32;
	localparam reg_addr_t REG_FIXED_AA        = 8'h33;
	localparam reg_addr_t REG_INDEX_HIGH      = 8'h40;
	localparam reg_addr_t REG_INDEX_LOW       = 8'h41;
	localparam reg_addr_t REG_STEP_RATE       = 8'hF0;
	localparam reg_addr_t REG_STEP_CMD        = 8'hFF;

	// Identity
	localparam logic [15:0] MCO_TYPE    = 16'hDD55;
	localparam logic [15:0] MCO_VERSION = 16'h0025;

	// Tick dividers, 100MHz master clock
	localparam int unsigned INDEX_TICK_DIV = 1000;   // 10us
	localparam int unsigned STEP_TICK_DIV  = 25000;  // 250us

endpackage
